// ==== source/hw_test_pkg.sv ====
// Ethernet hardware test
// Shared constants
package hw_test_pkg;

	// Frame buffer in 16-bit words
	localparam int mac_aw = 6;
	localparam int buf_words = 1 << mac_aw;
	localparam int max_frame_bytes = 2 * buf_words;

	// Local bus regions in lb_addr[23:20]
	localparam logic [3:0] lb_region_regs = 4'd0;
	localparam logic [3:0] lb_region_buf = 4'd1;
	localparam logic [3:0] lb_region_cfg = 4'd2;

	// Register offsets inside the register region
	localparam logic [3:0] reg_control = 4'd0;
	localparam logic [3:0] reg_tx_start = 4'd1;
	localparam logic [3:0] reg_status = 4'd2;

	localparam int lb_read_latency = 2;

	// Configuration table and SPI command
	localparam int cfg_words = 16;
	localparam logic [3:0] spi_cmd_write = 4'h1;

	// GMII framing
	localparam int preamble_bytes = 7;
	localparam int ifg_cycles = 12;
	// Reflected Ethernet polynomial
	localparam logic [31:0] crc_poly = 32'hedb88320;

	// Activity LED on-time
	localparam int act_bits = 4;

endpackage

// ==== source/spi_gate.sv ====
`timescale 1ns/1ps
// SPI configuration port
module spi_gate (
	input logic tx_clk,
	input logic arst_n,
	input logic sclk,
	input logic csb,
	input logic mosi,
	output logic config_s,
	output logic [3:0] config_a,
	output logic [7:0] config_d
);

	logic [1:0] sclk_s;
	logic [1:0] csb_s;
	logic [1:0] mosi_s;
	logic sclk_d;
	logic sclk_rise;
	logic word_done;
	logic [3:0] bit_cnt;
	logic [14:0] sr;

	assign sclk_rise = sclk_s[1] & ~sclk_d & ~csb_s[1];
	// Sixteenth bit arriving
	assign word_done = sclk_rise && bit_cnt == 4'd15;

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			sclk_s <= '0;
			csb_s <= '1;
			mosi_s <= '0;
			sclk_d <= 1'b0;
			bit_cnt <= '0;
			config_s <= 1'b0;
		end else begin
			sclk_s <= {sclk_s[0], sclk};
			csb_s <= {csb_s[0], csb};
			mosi_s <= {mosi_s[0], mosi};
			sclk_d <= sclk_s[1];
			config_s <= word_done && sr[14:11] == hw_test_pkg::spi_cmd_write;
			if (csb_s[1]) bit_cnt <= '0;
			else if (sclk_rise) bit_cnt <= bit_cnt + 4'd1;
		end
	end

	// MSB first; first byte is command and address
	always_ff @(posedge tx_clk) begin
		if (sclk_rise) sr <= {sr[13:0], mosi_s[1]};
		if (word_done) begin
			config_a <= sr[10:7];
			config_d <= {sr[6:0], mosi_s[1]};
		end
	end

endmodule

// ==== source/lb_demo_slave.sv ====
`timescale 1ns/1ps
// Local bus slave
// Registers, config table and buffer writes
module lb_demo_slave (
	input logic tx_clk,
	input logic arst_n,
	input logic [23:0] lb_addr,
	input logic [31:0] lb_data_out,
	input logic lb_strobe,
	input logic lb_rd,
	input logic config_s,
	input logic [3:0] config_a,
	input logic [7:0] config_d,
	input logic tx_busy,
	input logic tx_mac_done,
	output logic [31:0] lb_data_in,
	output logic lb_rd_valid,
	output logic host_write,
	output logic [hw_test_pkg::mac_aw-1:0] host_waddr,
	output logic [15:0] host_wdata,
	output logic tx_start,
	output logic [7:0] tx_len,
	output logic led_user_mode,
	output logic led1,
	output logic led2
);

	logic [3:0] region;
	logic [3:0] offset;
	logic wr;
	logic rd;
	logic reg_wr;
	logic start_ok;
	logic [2:0] ctrl;
	logic [7:0] done_cnt;
	logic [7:0] cfg [hw_test_pkg::cfg_words];
	logic [31:0] rd_mux;
	logic [hw_test_pkg::lb_read_latency-1:0] rd_v;
	logic [31:0] rd_d [hw_test_pkg::lb_read_latency];

	assign region = lb_addr[23:20];
	assign offset = lb_addr[3:0];
	assign wr = lb_strobe & ~lb_rd;
	assign rd = lb_strobe & lb_rd;
	assign reg_wr = wr && region == hw_test_pkg::lb_region_regs;
	assign {led2, led1, led_user_mode} = ctrl;

	// Buffer writes land in the sender on the strobe edge
	assign host_write = wr && region == hw_test_pkg::lb_region_buf;
	assign host_waddr = lb_addr[hw_test_pkg::mac_aw-1:0];
	assign host_wdata = lb_data_out[15:0];

	// Start only when idle and with a legal length
	assign start_ok = reg_wr && offset == hw_test_pkg::reg_tx_start && !tx_busy && !tx_start
		&& lb_data_out[7:0] != 8'd0 && lb_data_out[7:0] <= 8'(hw_test_pkg::max_frame_bytes);

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl <= '0;
			tx_start <= 1'b0;
			done_cnt <= '0;
			rd_v <= '0;
		end else begin
			tx_start <= start_ok;
			if (reg_wr && offset == hw_test_pkg::reg_control) ctrl <= lb_data_out[2:0];
			if (tx_mac_done) done_cnt <= done_cnt + 8'd1;
			rd_v <= {rd_v[hw_test_pkg::lb_read_latency-2:0], rd};
		end
	end

	always_ff @(posedge tx_clk) begin
		if (start_ok) tx_len <= lb_data_out[7:0];
	end

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < hw_test_pkg::cfg_words; i++) cfg[i] <= '0;
		end else if (config_s) begin
			cfg[config_a] <= config_d;
		end
	end

	// Read mux, buffer region reads as zero
	always_comb begin
		rd_mux = '0;
		if (region == hw_test_pkg::lb_region_cfg) begin
			rd_mux[7:0] = cfg[offset];
		end else if (region == hw_test_pkg::lb_region_regs) begin
			if (offset == hw_test_pkg::reg_control) rd_mux[2:0] = ctrl;
			if (offset == hw_test_pkg::reg_status) rd_mux = {16'd0, done_cnt, 7'd0, tx_busy};
		end
	end

	always_ff @(posedge tx_clk) begin
		rd_d[0] <= rd_mux;
		for (int i = 1; i < hw_test_pkg::lb_read_latency; i++) rd_d[i] <= rd_d[i-1];
	end

	assign lb_rd_valid = rd_v[hw_test_pkg::lb_read_latency-1];
	assign lb_data_in = rd_d[hw_test_pkg::lb_read_latency-1];

endmodule

// ==== source/frame_sender.sv ====
`timescale 1ns/1ps
// GMII frame sender
// Buffer, preamble, CRC-32 and gap
module frame_sender (
	input logic tx_clk,
	input logic arst_n,
	input logic host_write,
	input logic [hw_test_pkg::mac_aw-1:0] host_waddr,
	input logic [15:0] host_wdata,
	input logic tx_start,
	input logic [7:0] tx_len,
	output logic [7:0] vgmii_txd,
	output logic vgmii_tx_en,
	output logic vgmii_tx_er,
	output logic tx_busy,
	output logic tx_mac_done
);

	typedef enum logic [2:0] {st_idle, st_pre, st_sfd, st_data, st_crc, st_gap} state_t;

	state_t st;
	logic [7:0] cnt;
	logic [7:0] cnt_inc;
	logic [7:0] len;
	logic [31:0] crc;
	logic [15:0] mem [hw_test_pkg::buf_words];
	logic [15:0] mem_q;
	logic [hw_test_pkg::mac_aw-1:0] raddr;
	logic [7:0] cur_byte;
	logic cur_en;

	// One payload byte through the reflected CRC
	function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c ^ {24'd0, d};
		for (int i = 0; i < 8; i++) begin
			r = r[0] ? (r >> 1) ^ hw_test_pkg::crc_poly : r >> 1;
		end
		return r;
	endfunction

	assign cnt_inc = cnt + 8'd1;
	assign vgmii_tx_er = 1'b0;
	assign tx_busy = st != st_idle;

	// Word for the next even byte is fetched a cycle early
	assign raddr = (st == st_data) ? cnt_inc[hw_test_pkg::mac_aw:1] : '0;

	always_ff @(posedge tx_clk) begin
		if (host_write) mem[host_waddr] <= host_wdata;
		mem_q <= mem[raddr];
	end

	// Byte for the current state, low byte of a word first
	always_comb begin
		cur_byte = 8'h00;
		cur_en = 1'b1;
		case (st)
			st_pre: cur_byte = 8'h55;
			st_sfd: cur_byte = 8'hd5;
			st_data: cur_byte = cnt[0] ? mem_q[15:8] : mem_q[7:0];
			st_crc: cur_byte = ~crc[7:0];
			default: cur_en = 1'b0;
		endcase
	end

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			st <= st_idle;
			cnt <= '0;
			len <= '0;
			crc <= '1;
			vgmii_txd <= '0;
			vgmii_tx_en <= 1'b0;
			tx_mac_done <= 1'b0;
		end else begin
			// Outputs lag the state by one cycle
			vgmii_txd <= cur_byte;
			vgmii_tx_en <= cur_en;
			tx_mac_done <= st == st_gap && cnt == 8'd0;
			case (st)
				st_idle: if (tx_start) begin
					st <= st_pre;
					cnt <= '0;
					len <= tx_len;
					crc <= '1;
				end
				st_pre: if (cnt == 8'(hw_test_pkg::preamble_bytes - 1)) begin
					st <= st_sfd;
					cnt <= '0;
				end else cnt <= cnt_inc;
				st_sfd: st <= st_data;
				st_data: begin
					crc <= crc_step(crc, cur_byte);
					if (cnt == len - 8'd1) begin
						st <= st_crc;
						cnt <= '0;
					end else cnt <= cnt_inc;
				end
				st_crc: begin
					crc <= crc >> 8;
					if (cnt == 8'd3) begin
						st <= st_gap;
						cnt <= '0;
					end else cnt <= cnt_inc;
				end
				// Gap counted from the cycle tx_en drops
				st_gap: if (cnt == 8'(hw_test_pkg::ifg_cycles)) st <= st_idle;
				else cnt <= cnt_inc;
				default: st <= st_idle;
			endcase
		end
	end

endmodule

// ==== source/activity.sv ====
`timescale 1ns/1ps
// Activity LED stretcher
module activity (
	input logic tx_clk,
	input logic arst_n,
	input logic trigger,
	output logic led
);

	logic [hw_test_pkg::act_bits-1:0] cnt;

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			led <= 1'b0;
		end else if (trigger) begin
			cnt <= '1;
			led <= 1'b1;
		end else begin
			led <= cnt != '0;
			if (cnt != '0) cnt <= cnt - 1'b1;
		end
	end

endmodule

// ==== source/board_status.sv ====
`timescale 1ns/1ps
// Heartbeat, PHY reset and LEDs
module board_status #(
	parameter int phy_hold_bit = 21
) (
	input logic tx_clk,
	input logic arst_n,
	input logic clk_locked,
	input logic led_user_mode,
	input logic l1,
	input logic l2,
	output logic phy_rstn,
	output logic led0,
	output logic led1
);

	logic [phy_hold_bit:0] heartbeat;

	// PHY held in reset until the heartbeat bit first sets
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			heartbeat <= '0;
			phy_rstn <= 1'b0;
		end else begin
			heartbeat <= heartbeat + 1'b1;
			if (heartbeat[phy_hold_bit]) phy_rstn <= 1'b1;
			if (!clk_locked) phy_rstn <= 1'b0;
		end
	end

	assign led0 = led_user_mode ? l1 : heartbeat[phy_hold_bit];
	assign led1 = led_user_mode ? l2 : heartbeat[phy_hold_bit];

endmodule

// ==== source/hw_test.sv ====
`timescale 1ns/1ps
// Ethernet hardware test top
module hw_test #(
	parameter int phy_hold_bit = 21
) (
	input logic tx_clk,
	input logic arst_n,
	output logic [7:0] vgmii_txd,
	output logic vgmii_tx_en,
	output logic vgmii_tx_er,
	input logic sclk,
	input logic csb,
	input logic mosi,
	input logic clk_locked,
	input logic [23:0] lb_addr,
	input logic [31:0] lb_data_out,
	input logic lb_strobe,
	input logic lb_rd,
	output logic [31:0] lb_data_in,
	output logic lb_rd_valid,
	output logic phy_rstn,
	output logic [3:0] led
);

	logic config_s;
	logic [3:0] config_a;
	logic [7:0] config_d;
	logic host_write;
	logic [hw_test_pkg::mac_aw-1:0] host_waddr;
	logic [15:0] host_wdata;
	logic tx_start;
	logic [7:0] tx_len;
	logic tx_busy;
	logic tx_mac_done;
	logic led_user_mode;
	logic l1;
	logic l2;
	logic led0;
	logic led1;
	logic tx_led;
	logic tx_mon;

	assign tx_mon = vgmii_tx_en;
	assign led = {tx_led, 1'b0, led0, led1};

	// SPI configuration port
	spi_gate u_spi_gate (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.sclk(sclk), .csb(csb), .mosi(mosi),
		.config_s(config_s), .config_a(config_a), .config_d(config_d)
	);

	lb_demo_slave u_slave (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.lb_addr(lb_addr), .lb_data_out(lb_data_out),
		.lb_strobe(lb_strobe), .lb_rd(lb_rd),
		.config_s(config_s), .config_a(config_a), .config_d(config_d),
		.tx_busy(tx_busy), .tx_mac_done(tx_mac_done),
		.lb_data_in(lb_data_in), .lb_rd_valid(lb_rd_valid),
		.host_write(host_write), .host_waddr(host_waddr), .host_wdata(host_wdata),
		.tx_start(tx_start), .tx_len(tx_len),
		.led_user_mode(led_user_mode), .led1(l1), .led2(l2)
	);

	frame_sender u_sender (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.host_write(host_write), .host_waddr(host_waddr), .host_wdata(host_wdata),
		.tx_start(tx_start), .tx_len(tx_len),
		.vgmii_txd(vgmii_txd), .vgmii_tx_en(vgmii_tx_en), .vgmii_tx_er(vgmii_tx_er),
		.tx_busy(tx_busy), .tx_mac_done(tx_mac_done)
	);

	// Heartbeat, PHY reset and LEDs
	board_status #(.phy_hold_bit(phy_hold_bit)) u_board_status (
		.tx_clk(tx_clk), .arst_n(arst_n), .clk_locked(clk_locked),
		.led_user_mode(led_user_mode), .l1(l1), .l2(l2),
		.phy_rstn(phy_rstn), .led0(led0), .led1(led1)
	);

	activity u_activity (
		.tx_clk(tx_clk), .arst_n(arst_n), .trigger(tx_mon), .led(tx_led)
	);

endmodule

// ==== include/hw_test_tb_model.svh ====
// Testbench reference model
// CRC-32 and pseudo-random generator
`ifndef HW_TEST_TB_MODEL_SVH
`define HW_TEST_TB_MODEL_SVH

// Complemented Ethernet FCS over n bytes
function automatic logic [31:0] crc32(input logic [7:0] data [], input int n);
	logic [31:0] c;
	c = '1;
	for (int i = 0; i < n; i++) begin
		c = c ^ {24'd0, data[i]};
		for (int b = 0; b < 8; b++) begin
			c = c[0] ? (c >> 1) ^ hw_test_pkg::crc_poly : c >> 1;
		end
	end
	return ~c;
endfunction

// Next LCG state
function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1103515245 + 32'd12345;
endfunction

`endif

// ==== bench/hw_test_tb.sv ====
`timescale 1ns/1ps
// Ethernet hardware test bench
module hw_test_tb;

	localparam int phy_hold_bit = 6;
	localparam int half_period = 2;
	localparam logic [31:0] seed = 32'd20;
	// About 1500 cycles of tests plus a wide margin
	localparam int timeout_cycles = 20000;
	// From the cycle the start strobe is driven to the first tx_en cycle
	localparam int start_to_tx_en = 3;

	logic tx_clk;
	logic arst_n;
	logic [7:0] vgmii_txd;
	logic vgmii_tx_en;
	logic vgmii_tx_er;
	logic sclk;
	logic csb;
	logic mosi;
	logic clk_locked;
	logic [23:0] lb_addr;
	logic [31:0] lb_data_out;
	logic lb_strobe;
	logic lb_rd;
	logic [31:0] lb_data_in;
	logic lb_rd_valid;
	logic phy_rstn;
	logic [3:0] led;

	int cyc = 0;
	logic [31:0] lcg_state;
	logic [31:0] rd_data_q [$];
	int rd_cyc_q [$];
	logic [7:0] exp_bytes [$];
	logic [7:0] burst [$];
	logic tx_en_d = 1'b0;
	int tx_rise_cyc;
	int tx_fall_cyc;
	int bursts_seen = 0;
	int last_wr_cyc;
	logic [7:0] cfg_model [16];

	`include "hw_test_tb_model.svh"

	hw_test #(.phy_hold_bit(phy_hold_bit)) u_hw_test (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.vgmii_txd(vgmii_txd), .vgmii_tx_en(vgmii_tx_en), .vgmii_tx_er(vgmii_tx_er),
		.sclk(sclk), .csb(csb), .mosi(mosi), .clk_locked(clk_locked),
		.lb_addr(lb_addr), .lb_data_out(lb_data_out), .lb_strobe(lb_strobe), .lb_rd(lb_rd),
		.lb_data_in(lb_data_in), .lb_rd_valid(lb_rd_valid),
		.phy_rstn(phy_rstn), .led(led)
	);

	always #half_period tx_clk = ~tx_clk;

	always @(posedge tx_clk) begin
		cyc = cyc + 1;
		if (cyc >= timeout_cycles) begin
			$display("Timeout after %0d cycles, the tests did not finish", cyc);
			$display("Errors found");
			$fatal(1);
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s expected %0h, got %0h",
				$time, name, expected, actual);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_next(lcg_state);
		return lcg_state >> 8;
	endfunction

	function automatic logic [23:0] bus_addr(input logic [3:0] region, input int offset);
		return {region, 20'(offset)};
	endfunction

	// Read responses with the cycle they were seen in
	always @(negedge tx_clk) begin
		if (lb_rd_valid) begin
			rd_data_q.push_back(lb_data_in);
			rd_cyc_q.push_back(cyc);
		end
	end

	// Captures each tx_en burst and compares it with the expected frame
	always @(negedge tx_clk) begin
		check_value("vgmii_tx_er", 0, vgmii_tx_er);
		if (vgmii_tx_en) begin
			if (!tx_en_d) tx_rise_cyc = cyc;
			else check_value("led[3] during frame", 1, led[3]);
			burst.push_back(vgmii_txd);
		end else if (tx_en_d) begin
			tx_fall_cyc = cyc;
			check_value("vgmii_tx_en burst length", exp_bytes.size(), burst.size());
			foreach (burst[i]) check_value("vgmii_txd", exp_bytes[i], burst[i]);
			burst.delete();
			bursts_seen++;
		end
		tx_en_d = vgmii_tx_en;
	end

	task automatic bus_write(input logic [23:0] addr, input logic [31:0] data);
		@(negedge tx_clk);
		lb_addr = addr;
		lb_data_out = data;
		lb_rd = 1'b0;
		lb_strobe = 1'b1;
		last_wr_cyc = cyc;
		@(negedge tx_clk);
		lb_strobe = 1'b0;
	endtask

	task automatic bus_read(input logic [23:0] addr, output logic [31:0] data);
		int issue;
		@(negedge tx_clk);
		lb_addr = addr;
		lb_rd = 1'b1;
		lb_strobe = 1'b1;
		issue = cyc;
		@(negedge tx_clk);
		lb_strobe = 1'b0;
		lb_rd = 1'b0;
		while (rd_data_q.size() == 0) @(posedge tx_clk);
		check_value("lb_rd_valid cycle", issue + hw_test_pkg::lb_read_latency,
			rd_cyc_q.pop_front());
		data = rd_data_q.pop_front();
	endtask

	// Two reads on consecutive cycles
	task automatic read_pair(input logic [23:0] a0, input logic [23:0] a1,
		output logic [31:0] d0, output logic [31:0] d1);
		int issue;
		@(negedge tx_clk);
		lb_addr = a0;
		lb_rd = 1'b1;
		lb_strobe = 1'b1;
		issue = cyc;
		@(negedge tx_clk);
		lb_addr = a1;
		@(negedge tx_clk);
		lb_strobe = 1'b0;
		lb_rd = 1'b0;
		while (rd_data_q.size() < 2) @(posedge tx_clk);
		check_value("lb_rd_valid cycle", issue + hw_test_pkg::lb_read_latency,
			rd_cyc_q.pop_front());
		check_value("lb_rd_valid cycle", issue + 1 + hw_test_pkg::lb_read_latency,
			rd_cyc_q.pop_front());
		d0 = rd_data_q.pop_front();
		d1 = rd_data_q.pop_front();
	endtask

	// MSB first with four tx_clk cycles per SCLK phase
	task automatic spi_send(input logic [7:0] b0, input logic [7:0] b1);
		logic [15:0] word;
		word = {b0, b1};
		@(negedge tx_clk);
		csb = 1'b0;
		for (int i = 15; i >= 0; i--) begin
			mosi = word[i];
			sclk = 1'b0;
			repeat (4) @(negedge tx_clk);
			sclk = 1'b1;
			repeat (4) @(negedge tx_clk);
		end
		sclk = 1'b0;
		repeat (4) @(negedge tx_clk);
		csb = 1'b1;
		repeat (4) @(negedge tx_clk);
	endtask

	// Random payload into the buffer and the expected burst built alongside
	task automatic load_frame(input int len);
		logic [7:0] payload [];
		logic [7:0] hi;
		logic [31:0] fcs;
		payload = new[len];
		for (int i = 0; i < len; i++) payload[i] = 8'(rand_next());
		for (int w = 0; w < (len + 1) / 2; w++) begin
			hi = (2 * w + 1 < len) ? payload[2 * w + 1] : 8'h00;
			bus_write(bus_addr(hw_test_pkg::lb_region_buf, w), {16'd0, hi, payload[2 * w]});
		end
		fcs = crc32(payload, len);
		exp_bytes.delete();
		repeat (hw_test_pkg::preamble_bytes) exp_bytes.push_back(8'h55);
		exp_bytes.push_back(8'hd5);
		foreach (payload[i]) exp_bytes.push_back(payload[i]);
		for (int i = 0; i < 4; i++) exp_bytes.push_back(fcs[8 * i +: 8]);
	endtask

	task automatic wait_bursts(input int n);
		while (bursts_seen < n) @(posedge tx_clk);
	endtask

	task automatic wait_idle();
		logic [31:0] st;
		logic [23:0] addr;
		st = 32'd1;
		addr = bus_addr(hw_test_pkg::lb_region_regs, hw_test_pkg::reg_status);
		while (st[0]) bus_read(addr, st);
	endtask

	initial begin
		logic [31:0] d0;
		logic [31:0] d1;
		logic [23:0] a_ctrl;
		logic [23:0] a_stat;
		logic [23:0] a_start;
		logic [3:0] cfg_a;
		logic [7:0] cfg_d;
		int len;
		int release_cyc;
		tx_clk = 1'b0;
		arst_n = 1'b0;
		sclk = 1'b0;
		csb = 1'b1;
		mosi = 1'b0;
		clk_locked = 1'b1;
		lb_addr = '0;
		lb_data_out = '0;
		lb_strobe = 1'b0;
		lb_rd = 1'b0;
		lcg_state = seed;
		foreach (cfg_model[i]) cfg_model[i] = 8'h00;
		a_ctrl = bus_addr(hw_test_pkg::lb_region_regs, hw_test_pkg::reg_control);
		a_stat = bus_addr(hw_test_pkg::lb_region_regs, hw_test_pkg::reg_status);
		a_start = bus_addr(hw_test_pkg::lb_region_regs, hw_test_pkg::reg_tx_start);
		repeat (4) @(negedge tx_clk);
		arst_n = 1'b1;
		release_cyc = cyc;

		// PHY reset held until the heartbeat bit sets and released one cycle later
		while (!phy_rstn) @(negedge tx_clk);
		check_value("phy_rstn release cycle", (1 << phy_hold_bit) + 1, cyc - release_cyc);

		// Control register and back-to-back reads
		bus_write(a_ctrl, 32'h5);
		bus_read(a_ctrl, d0);
		check_value("lb_data_in control", 32'h5, d0);
		read_pair(a_ctrl, a_stat, d0, d1);
		check_value("lb_data_in first of pair", 32'h5, d0);
		check_value("lb_data_in second of pair", 32'h0, d1);

		// User mode LEDs show control bits 1 and 2
		check_value("led[2:0]", {1'b0, 1'b0, 1'b1}, led[2:0]);
		bus_write(a_ctrl, 32'h3);
		check_value("led[2:0]", {1'b0, 1'b1, 1'b0}, led[2:0]);

		// Random frame
		len = rand_next() % hw_test_pkg::max_frame_bytes + 1;
		load_frame(len);
		bus_write(a_start, len);
		wait_bursts(1);
		check_value("vgmii_tx_en rise cycle", start_to_tx_en, tx_rise_cyc - last_wr_cyc);
		@(negedge tx_clk);
		while (led[3]) @(negedge tx_clk);
		check_value("led[3] off cycle", 1 << hw_test_pkg::act_bits, cyc - tx_fall_cyc);
		wait_idle();
		bus_read(a_stat, d0);
		check_value("lb_data_in status", {16'd0, 8'd1, 7'd0, 1'b0}, d0);

		// Second start during a frame is dropped
		len = rand_next() % 32 + 1;
		load_frame(len);
		bus_write(a_start, len);
		bus_write(a_start, len);
		bus_read(a_stat, d0);
		check_value("lb_data_in status busy", {16'd0, 8'd1, 7'd0, 1'b1}, d0);
		wait_bursts(2);
		wait_idle();
		repeat (40) @(negedge tx_clk);
		check_value("tx_en burst count", 2, bursts_seen);
		bus_read(a_stat, d0);
		check_value("lb_data_in status", {16'd0, 8'd2, 7'd0, 1'b0}, d0);

		// SPI config writes and then one with a foreign command nibble
		for (int i = 0; i < 3; i++) begin
			cfg_a = 4'(3 + 6 * i);
			cfg_d = 8'(rand_next());
			spi_send({hw_test_pkg::spi_cmd_write, cfg_a}, cfg_d);
			cfg_model[cfg_a] = cfg_d;
		end
		spi_send({4'h2, 4'd3}, ~cfg_model[3]);
		for (int a = 0; a < hw_test_pkg::cfg_words; a++) begin
			bus_read(bus_addr(hw_test_pkg::lb_region_cfg, a), d0);
			check_value("lb_data_in config", {24'd0, cfg_model[a]}, d0);
		end

		// Loss of clock lock puts the PHY back in reset
		@(negedge tx_clk);
		clk_locked = 1'b0;
		@(negedge tx_clk);
		check_value("phy_rstn", 0, phy_rstn);
		clk_locked = 1'b1;

		$display("No errors");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+include
source/hw_test_pkg.sv
source/spi_gate.sv
source/lb_demo_slave.sv
source/frame_sender.sv
source/activity.sv
source/board_status.sv
source/hw_test.sv
bench/hw_test_tb.sv

// ==== Bender.yml ====
package:
  name: hw_test

sources:
  - files:
      - source/hw_test_pkg.sv
      - source/spi_gate.sv
      - source/lb_demo_slave.sv
      - source/frame_sender.sv
      - source/activity.sv
      - source/board_status.sv
      - source/hw_test.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/hw_test_tb.sv
